//--- common/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

	typedef logic [`EX_XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [$clog2(`EX_IDLE_SLOT + 1)-1:0] thread_id_t;  // idle code included
	typedef logic [6:0] op_class_t;

	// one-hot class bits, the rest execute as nop
	localparam int CLASS_REG = 0;
	localparam int CLASS_BRANCH = 1;

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_fields_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fields_t;

	// same word, register-op or branch view
	typedef union packed {
		r_fields_t r;
		b_fields_t b;
	} instr_u;

endpackage

//--- common/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

`define EX_NUM_THREADS 4
`define EX_NUM_ALUS 2
`define EX_QUEUE_DEPTH 3  // per thread
`define EX_XLEN 32

// slot code for "no thread this cycle"
`define EX_IDLE_SLOT 4

`endif

//--- hdl/alu.sv
module alu (
	input  ex_pkg::instr_u    ins,
	input  ex_pkg::word_t     pc,
	input  ex_pkg::word_t     op1,
	input  ex_pkg::word_t     op2,
	input  ex_pkg::reg_addr_t rd_addr_in,
	input  ex_pkg::op_class_t oh,
	output ex_pkg::reg_addr_t rd_addr,
	output ex_pkg::word_t     rd_data,
	output logic              rd_wen,
	output ex_pkg::word_t     jump_addr,
	output logic              jump_en
);
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

	logic          is_reg;
	logic          is_br;
	logic          op_ok;
	logic          take;
	ex_pkg::word_t result;
	ex_pkg::word_t imm_b;

	assign is_reg = oh[ex_pkg::CLASS_REG];
	assign is_br = oh[ex_pkg::CLASS_BRANCH];

	assign imm_b = {{19{ins.b.imm12}}, ins.b.imm12, ins.b.imm11, ins.b.imm10_5,
		ins.b.imm4_1, 1'b0};

	always_comb begin
		result = '0;
		op_ok = 1'b1;
		case (ins.r.funct3)
			F3_ADD_SUB: result = ins.r.funct7[5] ? op1 - op2 : op1 + op2;  // funct7 0x20 is sub
			F3_XOR: result = op1 ^ op2;
			F3_OR: result = op1 | op2;
			F3_AND: result = op1 & op2;
			default: op_ok = 1'b0;
		endcase
	end

	always_comb begin
		case (ins.b.funct3)
			F3_BEQ: take = (op1 == op2);
			F3_BNE: take = (op1 != op2);
			default: take = 1'b0;
		endcase
	end

	assign rd_wen = is_reg && op_ok && (rd_addr_in != '0);  // x0 never written
	assign rd_addr = is_reg ? rd_addr_in : '0;
	assign rd_data = rd_wen ? result : '0;
	assign jump_en = is_br && take;
	assign jump_addr = is_br ? pc + imm_b : '0;

endmodule

//--- hdl/dispatch_crossbar.sv
`include "ex_settings.svh"

module dispatch_crossbar (
	input  logic               clk,
	input  logic               rst,
	input  ex_pkg::word_t      ins[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      op1[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      op2[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      pc[`EX_NUM_THREADS-1:0],
	input  ex_pkg::reg_addr_t  rd_addr_in[`EX_NUM_THREADS-1:0],
	input  ex_pkg::op_class_t  oh[`EX_NUM_THREADS-1:0],
	input  logic               head_valid[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      head_ins[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      head_pc[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      head_op1[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      head_op2[`EX_NUM_THREADS-1:0],
	input  ex_pkg::reg_addr_t  head_rd_addr[`EX_NUM_THREADS-1:0],
	input  ex_pkg::op_class_t  head_oh[`EX_NUM_THREADS-1:0],
	input  ex_pkg::thread_id_t dispatch_threads[`EX_NUM_ALUS-1:0],
	input  ex_pkg::reg_addr_t  alu_rd_addr[`EX_NUM_ALUS-1:0],
	input  ex_pkg::word_t      alu_rd_data[`EX_NUM_ALUS-1:0],
	input  logic               alu_rd_wen[`EX_NUM_ALUS-1:0],
	input  ex_pkg::word_t      alu_jump_addr[`EX_NUM_ALUS-1:0],
	input  logic               alu_jump_en[`EX_NUM_ALUS-1:0],
	output ex_pkg::instr_u     alu_ins[`EX_NUM_ALUS-1:0],
	output ex_pkg::word_t      alu_pc[`EX_NUM_ALUS-1:0],
	output ex_pkg::word_t      alu_op1[`EX_NUM_ALUS-1:0],
	output ex_pkg::word_t      alu_op2[`EX_NUM_ALUS-1:0],
	output ex_pkg::reg_addr_t  alu_rd_addr_in[`EX_NUM_ALUS-1:0],
	output ex_pkg::op_class_t  alu_oh[`EX_NUM_ALUS-1:0],
	output logic               taken[`EX_NUM_THREADS-1:0],
	output ex_pkg::reg_addr_t  rd_addr[`EX_NUM_THREADS-1:0],
	output ex_pkg::word_t      rd_data[`EX_NUM_THREADS-1:0],
	output logic               rd_wen[`EX_NUM_THREADS-1:0],
	output ex_pkg::word_t      jump_addr[`EX_NUM_THREADS-1:0],
	output logic               jump_en[`EX_NUM_THREADS-1:0]
);
	localparam int NT = `EX_NUM_THREADS;
	localparam int NA = `EX_NUM_ALUS;
	localparam int TW = $clog2(NT);

	// operand select per slot
	always_comb begin
		logic [TW-1:0] t;
		for (int s = 0; s < NA; s++) begin
			t = dispatch_threads[s][TW-1:0];
			alu_ins[s] = '0;
			alu_pc[s] = '0;
			alu_op1[s] = '0;
			alu_op2[s] = '0;
			alu_rd_addr_in[s] = '0;
			alu_oh[s] = '0;  // idle slot runs a nop
			if (dispatch_threads[s] < NT) begin
				alu_ins[s] = head_valid[t] ? head_ins[t] : ins[t];
				alu_pc[s] = head_valid[t] ? head_pc[t] : pc[t];
				alu_op1[s] = head_valid[t] ? head_op1[t] : op1[t];
				alu_op2[s] = head_valid[t] ? head_op2[t] : op2[t];
				alu_rd_addr_in[s] = head_valid[t] ? head_rd_addr[t] : rd_addr_in[t];
				alu_oh[s] = head_valid[t] ? head_oh[t] : oh[t];  // else bypass from decode
			end
		end
	end

	// results back to the owning thread
	always_comb begin
		logic [TW-1:0] t;
		for (int i = 0; i < NT; i++) begin
			taken[i] = 1'b0;
			rd_addr[i] = '0;
			rd_data[i] = '0;
			rd_wen[i] = 1'b0;
			jump_addr[i] = '0;
			jump_en[i] = 1'b0;
		end
		for (int s = 0; s < NA; s++) begin
			t = dispatch_threads[s][TW-1:0];
			if (dispatch_threads[s] < NT) begin
				taken[t] = 1'b1;
				rd_addr[t] = alu_rd_addr[s];
				rd_data[t] = alu_rd_data[s];
				rd_wen[t] = alu_rd_wen[s];
				jump_addr[t] = alu_jump_addr[s];
				jump_en[t] = alu_jump_en[s];
			end
		end
	end

	// scheduler contract
	for (genvar s = 0; s < NA; s++) begin : g_slot_chk
		assert property (@(posedge clk) disable iff (!rst)
			dispatch_threads[s] <= `EX_IDLE_SLOT);
		for (genvar u = s + 1; u < NA; u++) begin : g_pair_chk
			assert property (@(posedge clk) disable iff (!rst)
				dispatch_threads[s] != `EX_IDLE_SLOT |->
				dispatch_threads[s] != dispatch_threads[u]);
		end
	end

endmodule

//--- hdl/ex_stage.sv
`include "ex_settings.svh"

module ex_stage (
	input  logic               clk,
	input  logic               rst,
	input  ex_pkg::word_t      ins[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      op1[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      op2[`EX_NUM_THREADS-1:0],
	input  ex_pkg::word_t      pc[`EX_NUM_THREADS-1:0],
	input  ex_pkg::reg_addr_t  rd_addr_in[`EX_NUM_THREADS-1:0],
	input  ex_pkg::reg_addr_t  rs1_addr[`EX_NUM_THREADS-1:0],
	input  ex_pkg::reg_addr_t  rs2_addr[`EX_NUM_THREADS-1:0],
	input  ex_pkg::op_class_t  oh[`EX_NUM_THREADS-1:0],
	input  ex_pkg::thread_id_t dispatch_threads[`EX_NUM_ALUS-1:0],
	output ex_pkg::reg_addr_t  rd_addr[`EX_NUM_THREADS-1:0],
	output ex_pkg::word_t      rd_data[`EX_NUM_THREADS-1:0],
	output logic               rd_wen[`EX_NUM_THREADS-1:0],
	output ex_pkg::word_t      jump_addr[`EX_NUM_THREADS-1:0],
	output logic               jump_en[`EX_NUM_THREADS-1:0]
);
	logic              head_valid[`EX_NUM_THREADS-1:0];
	ex_pkg::word_t     head_ins[`EX_NUM_THREADS-1:0];
	ex_pkg::word_t     head_pc[`EX_NUM_THREADS-1:0];
	ex_pkg::word_t     head_op1[`EX_NUM_THREADS-1:0];
	ex_pkg::word_t     head_op2[`EX_NUM_THREADS-1:0];
	ex_pkg::reg_addr_t head_rd_addr[`EX_NUM_THREADS-1:0];
	ex_pkg::op_class_t head_oh[`EX_NUM_THREADS-1:0];
	logic              taken[`EX_NUM_THREADS-1:0];
	ex_pkg::instr_u    alu_ins[`EX_NUM_ALUS-1:0];
	ex_pkg::word_t     alu_pc[`EX_NUM_ALUS-1:0];
	ex_pkg::word_t     alu_op1[`EX_NUM_ALUS-1:0];
	ex_pkg::word_t     alu_op2[`EX_NUM_ALUS-1:0];
	ex_pkg::reg_addr_t alu_rd_addr_in[`EX_NUM_ALUS-1:0];
	ex_pkg::op_class_t alu_oh[`EX_NUM_ALUS-1:0];
	ex_pkg::reg_addr_t alu_rd_addr[`EX_NUM_ALUS-1:0];
	ex_pkg::word_t     alu_rd_data[`EX_NUM_ALUS-1:0];
	logic              alu_rd_wen[`EX_NUM_ALUS-1:0];
	ex_pkg::word_t     alu_jump_addr[`EX_NUM_ALUS-1:0];
	logic              alu_jump_en[`EX_NUM_ALUS-1:0];

	for (genvar i = 0; i < `EX_NUM_THREADS; i++) begin : g_thread
		thread_queue u_queue (
			.clk          (clk),
			.rst          (rst),
			.ins          (ins[i]),
			.op1          (op1[i]),
			.op2          (op2[i]),
			.pc           (pc[i]),
			.rd_addr_in   (rd_addr_in[i]),
			.rs1_addr     (rs1_addr[i]),
			.rs2_addr     (rs2_addr[i]),
			.oh           (oh[i]),
			.taken        (taken[i]),
			.flush        (jump_en[i]),  // thread redirect empties its queue
			.wb_addr      (rd_addr[i]),
			.wb_data      (rd_data[i]),
			.wb_en        (rd_wen[i]),
			.head_valid   (head_valid[i]),
			.head_ins     (head_ins[i]),
			.head_pc      (head_pc[i]),
			.head_op1     (head_op1[i]),
			.head_op2     (head_op2[i]),
			.head_rd_addr (head_rd_addr[i]),
			.head_oh      (head_oh[i])
		);
	end

	dispatch_crossbar u_xbar (
		.clk              (clk),
		.rst              (rst),
		.ins              (ins),
		.op1              (op1),
		.op2              (op2),
		.pc               (pc),
		.rd_addr_in       (rd_addr_in),
		.oh               (oh),
		.head_valid       (head_valid),
		.head_ins         (head_ins),
		.head_pc          (head_pc),
		.head_op1         (head_op1),
		.head_op2         (head_op2),
		.head_rd_addr     (head_rd_addr),
		.head_oh          (head_oh),
		.dispatch_threads (dispatch_threads),
		.alu_rd_addr      (alu_rd_addr),
		.alu_rd_data      (alu_rd_data),
		.alu_rd_wen       (alu_rd_wen),
		.alu_jump_addr    (alu_jump_addr),
		.alu_jump_en      (alu_jump_en),
		.alu_ins          (alu_ins),
		.alu_pc           (alu_pc),
		.alu_op1          (alu_op1),
		.alu_op2          (alu_op2),
		.alu_rd_addr_in   (alu_rd_addr_in),
		.alu_oh           (alu_oh),
		.taken            (taken),
		.rd_addr          (rd_addr),
		.rd_data          (rd_data),
		.rd_wen           (rd_wen),
		.jump_addr        (jump_addr),
		.jump_en          (jump_en)
	);

	for (genvar s = 0; s < `EX_NUM_ALUS; s++) begin : g_slot
		alu u_alu (
			.ins        (alu_ins[s]),
			.pc         (alu_pc[s]),
			.op1        (alu_op1[s]),
			.op2        (alu_op2[s]),
			.rd_addr_in (alu_rd_addr_in[s]),
			.oh         (alu_oh[s]),
			.rd_addr    (alu_rd_addr[s]),
			.rd_data    (alu_rd_data[s]),
			.rd_wen     (alu_rd_wen[s]),
			.jump_addr  (alu_jump_addr[s]),
			.jump_en    (alu_jump_en[s])
		);
	end

endmodule

//--- run.sh
#!/bin/sh
# build and run the ex_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tb_ex_stage -Mdir obj_dir -o sim_tb_ex_stage
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_ex_stage
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

exit 0

//--- tb.f
+incdir+common
+incdir+tests
common/ex_pkg.sv
thread_queue/thread_queue.sv
hdl/alu.sv
hdl/dispatch_crossbar.sv
hdl/ex_stage.sv
tests/tb_ex_stage.sv

//--- tests/tb_ex_vectors.svh
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

// register op with its own fields encoded into the word
task automatic present_r(input int row, input int t, input ex_pkg::word_t addr,
	input logic [6:0] f7, input logic [2:0] f3, input ex_pkg::reg_addr_t rd,
	input ex_pkg::reg_addr_t rs1, input ex_pkg::reg_addr_t rs2,
	input ex_pkg::word_t a, input ex_pkg::word_t b);
	v_ins[row][t] = {f7, rs2, rs1, f3, rd, 7'b0110011};
	v_pc[row][t] = addr;
	v_op1[row][t] = a;
	v_op2[row][t] = b;
	v_rd[row][t] = rd;
	v_rs1[row][t] = rs1;
	v_rs2[row][t] = rs2;
	v_oh[row][t] = 7'b0000001;
endtask

task automatic present_b(input int row, input int t, input ex_pkg::word_t addr,
	input logic [12:0] imm, input logic [2:0] f3, input ex_pkg::reg_addr_t rs1,
	input ex_pkg::reg_addr_t rs2, input ex_pkg::word_t a, input ex_pkg::word_t b);
	v_ins[row][t] = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	v_pc[row][t] = addr;
	v_op1[row][t] = a;
	v_op2[row][t] = b;
	v_rd[row][t] = '0;
	v_rs1[row][t] = rs1;
	v_rs2[row][t] = rs2;
	v_oh[row][t] = 7'b0000010;
endtask

task automatic schedule(input int row, input ex_pkg::thread_id_t s0,
	input ex_pkg::thread_id_t s1);
	v_slot[row][0] = s0;
	v_slot[row][1] = s1;
endtask

task automatic result_on(input int row, input int t, input ex_pkg::reg_addr_t rd,
	input ex_pkg::word_t data);
	e_wen[row][t] = 1'b1;
	e_rd[row][t] = rd;
	e_data[row][t] = data;
endtask

task automatic jump_on(input int row, input int t, input ex_pkg::word_t addr);
	e_jen[row][t] = 1'b1;
	e_jaddr[row][t] = addr;
endtask

task automatic build_table();
	ex_pkg::word_t a[0:23];
	for (int i = 0; i < 24; i++) begin
		a[i] = $random(seed);
	end
	v_ins = '{default: '0};
	v_op1 = '{default: '0};
	v_op2 = '{default: '0};
	v_pc = '{default: '0};
	v_rd = '{default: '0};
	v_rs1 = '{default: '0};
	v_rs2 = '{default: '0};
	v_oh = '{default: '0};  // class 0, nothing presented
	v_slot = '{default: IDLE};
	e_wen = '{default: 1'b0};
	e_rd = '{default: '0};
	e_data = '{default: '0};
	e_jen = '{default: 1'b0};
	e_jaddr = '{default: '0};
	// add straight from decode
	present_r(0, 0, 32'h100, 7'h00, 3'b000, 5'd1, 5'd2, 5'd3, a[0], a[1]);
	schedule(0, 3'd0, IDLE);
	result_on(0, 0, 5'd1, a[0] + a[1]);
	// thread 1 queues pc 200, 204, then 200 again
	present_r(1, 1, 32'h200, 7'h00, 3'b000, 5'd4, 5'd2, 5'd3, a[2], a[3]);
	present_r(2, 1, 32'h204, 7'h00, 3'b100, 5'd6, 5'd7, 5'd8, a[4], a[5]);
	present_r(3, 1, 32'h200, 7'h00, 3'b000, 5'd4, 5'd2, 5'd3, a[2], a[3]);
	schedule(4, 3'd1, IDLE);
	result_on(4, 1, 5'd4, a[2] + a[3]);
	schedule(5, IDLE, 3'd1);
	result_on(5, 1, 5'd6, a[4] ^ a[5]);
	schedule(6, 3'd1, IDLE);  // queue empty, repeat never stored
	// both slots busy
	present_r(7, 2, 32'h300, 7'h20, 3'b000, 5'd9, 5'd2, 5'd3, a[6], a[7]);
	present_r(7, 3, 32'h400, 7'h00, 3'b100, 5'd10, 5'd2, 5'd3, a[8], a[9]);
	schedule(7, 3'd2, 3'd3);
	result_on(7, 2, 5'd9, a[6] - a[7]);
	result_on(7, 3, 5'd10, a[8] ^ a[9]);
	present_r(8, 2, 32'h304, 7'h00, 3'b000, 5'd11, 5'd2, 5'd3, a[10], a[11]);
	schedule(8, IDLE, 3'd2);
	result_on(8, 2, 5'd11, a[10] + a[11]);
	// x5 then x0 written while the third entry waits
	present_r(9, 0, 32'h500, 7'h00, 3'b000, 5'd5, 5'd12, 5'd13, a[12], a[13]);
	present_r(10, 0, 32'h504, 7'h00, 3'b000, 5'd0, 5'd14, 5'd15, a[14], a[15]);
	present_r(11, 0, 32'h508, 7'h00, 3'b000, 5'd16, 5'd5, 5'd0, a[16], a[17]);
	schedule(12, 3'd0, IDLE);
	result_on(12, 0, 5'd5, a[12] + a[13]);
	schedule(13, 3'd0, IDLE);
	schedule(14, 3'd0, IDLE);
	result_on(14, 0, 5'd16, a[12] + a[13] + a[17]);
	// beq back by 32 with an add queued behind it
	present_b(15, 3, 32'h600, 13'h1fe0, 3'b000, 5'd18, 5'd19, a[18], a[18]);
	present_r(16, 3, 32'h604, 7'h00, 3'b000, 5'd20, 5'd2, 5'd3, a[19], a[20]);
	present_b(17, 2, 32'h700, 13'h1ff8, 3'b001, 5'd2, 5'd3, a[21], a[21]);
	schedule(17, 3'd3, 3'd2);
	jump_on(17, 3, 32'h600 - 32'h20);
	present_r(18, 3, 32'h608, 7'h00, 3'b000, 5'd21, 5'd2, 5'd3, a[22], a[23]);
	schedule(18, IDLE, 3'd3);
	result_on(18, 3, 5'd21, a[22] + a[23]);
endtask

`endif

//--- tests/tb_ex_stage.sv
`include "ex_settings.svh"

module tb_ex_stage;
	localparam int NT = `EX_NUM_THREADS;
	localparam int NA = `EX_NUM_ALUS;
	localparam int NROWS = 20;
	localparam int IDLE_TIMEOUT = 16;  // cycles
	localparam ex_pkg::thread_id_t IDLE = `EX_IDLE_SLOT;

	logic               clk;
	logic               rst;
	ex_pkg::word_t      ins[NT-1:0];
	ex_pkg::word_t      op1[NT-1:0];
	ex_pkg::word_t      op2[NT-1:0];
	ex_pkg::word_t      pc[NT-1:0];
	ex_pkg::reg_addr_t  rd_addr_in[NT-1:0];
	ex_pkg::reg_addr_t  rs1_addr[NT-1:0];
	ex_pkg::reg_addr_t  rs2_addr[NT-1:0];
	ex_pkg::op_class_t  oh[NT-1:0];
	ex_pkg::thread_id_t dispatch_threads[NA-1:0];
	ex_pkg::reg_addr_t  rd_addr[NT-1:0];
	ex_pkg::word_t      rd_data[NT-1:0];
	logic               rd_wen[NT-1:0];
	ex_pkg::word_t      jump_addr[NT-1:0];
	logic               jump_en[NT-1:0];
	integer             seed;

	// one row per cycle
	ex_pkg::word_t      v_ins[NROWS][NT];
	ex_pkg::word_t      v_op1[NROWS][NT];
	ex_pkg::word_t      v_op2[NROWS][NT];
	ex_pkg::word_t      v_pc[NROWS][NT];
	ex_pkg::reg_addr_t  v_rd[NROWS][NT];
	ex_pkg::reg_addr_t  v_rs1[NROWS][NT];
	ex_pkg::reg_addr_t  v_rs2[NROWS][NT];
	ex_pkg::op_class_t  v_oh[NROWS][NT];
	ex_pkg::thread_id_t v_slot[NROWS][NA];
	logic               e_wen[NROWS][NT];
	ex_pkg::reg_addr_t  e_rd[NROWS][NT];
	ex_pkg::word_t      e_data[NROWS][NT];
	logic               e_jen[NROWS][NT];
	ex_pkg::word_t      e_jaddr[NROWS][NT];

	`include "tb_ex_vectors.svh"

	ex_stage UUT (
		.clk              (clk),
		.rst              (rst),
		.ins              (ins),
		.op1              (op1),
		.op2              (op2),
		.pc               (pc),
		.rd_addr_in       (rd_addr_in),
		.rs1_addr         (rs1_addr),
		.rs2_addr         (rs2_addr),
		.oh               (oh),
		.dispatch_threads (dispatch_threads),
		.rd_addr          (rd_addr),
		.rd_data          (rd_data),
		.rd_wen           (rd_wen),
		.jump_addr        (jump_addr),
		.jump_en          (jump_en)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "output mismatch");
		end
	endtask

	function automatic logic outputs_quiet();
		logic q;
		q = 1'b1;
		for (int t = 0; t < NT; t++) begin
			q = q & !rd_wen[t] & !jump_en[t];
		end
		return q;
	endfunction

	initial begin
		logic quiet;
		clk = 1'b0;
		rst = 1'b0;
		seed = 32'he161_0d97;
		for (int t = 0; t < NT; t++) begin
			ins[t] = '0;
			op1[t] = '0;
			op2[t] = '0;
			pc[t] = '0;
			rd_addr_in[t] = '0;
			rs1_addr[t] = '0;
			rs2_addr[t] = '0;
			oh[t] = '0;
		end
		for (int s = 0; s < NA; s++) begin
			dispatch_threads[s] = IDLE;
		end
		build_table();
		repeat (8) @(posedge clk);
		rst <= 1'b1;
		quiet = 1'b0;
		for (int n = 0; n < IDLE_TIMEOUT && !quiet; n++) begin
			@(posedge clk);
			#1;
			quiet = outputs_quiet();
		end
		if (!quiet) begin
			$display("timeout: outputs still active after reset");
			$display("tests failed");
			$fatal(1, "idle wait timed out");
		end
		for (int r = 0; r < NROWS; r++) begin
			@(posedge clk);
			for (int t = 0; t < NT; t++) begin
				ins[t] <= v_ins[r][t];
				op1[t] <= v_op1[r][t];
				op2[t] <= v_op2[r][t];
				pc[t] <= v_pc[r][t];
				rd_addr_in[t] <= v_rd[r][t];
				rs1_addr[t] <= v_rs1[r][t];
				rs2_addr[t] <= v_rs2[r][t];
				oh[t] <= v_oh[r][t];
			end
			for (int s = 0; s < NA; s++) begin
				dispatch_threads[s] <= v_slot[r][s];
			end
			#1;  // outputs are combinational
			for (int t = 0; t < NT; t++) begin
				check_value($sformatf("row %0d thread %0d rd_wen", r, t), rd_wen[t],
					e_wen[r][t]);
				check_value($sformatf("row %0d thread %0d rd_addr", r, t), rd_addr[t],
					e_rd[r][t]);
				check_value($sformatf("row %0d thread %0d rd_data", r, t), rd_data[t],
					e_data[r][t]);
				check_value($sformatf("row %0d thread %0d jump_en", r, t), jump_en[t],
					e_jen[r][t]);
				if (e_jen[r][t]) begin
					check_value($sformatf("row %0d thread %0d jump_addr", r, t),
						jump_addr[t], e_jaddr[r][t]);
				end
			end
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- thread_queue/thread_queue.sv
`include "ex_settings.svh"

module thread_queue (
	input  logic              clk,
	input  logic              rst,
	input  ex_pkg::word_t     ins,
	input  ex_pkg::word_t     op1,
	input  ex_pkg::word_t     op2,
	input  ex_pkg::word_t     pc,
	input  ex_pkg::reg_addr_t rd_addr_in,
	input  ex_pkg::reg_addr_t rs1_addr,
	input  ex_pkg::reg_addr_t rs2_addr,
	input  ex_pkg::op_class_t oh,
	input  logic              taken,
	input  logic              flush,
	input  ex_pkg::reg_addr_t wb_addr,
	input  ex_pkg::word_t     wb_data,
	input  logic              wb_en,
	output logic              head_valid,
	output ex_pkg::word_t     head_ins,
	output ex_pkg::word_t     head_pc,
	output ex_pkg::word_t     head_op1,
	output ex_pkg::word_t     head_op2,
	output ex_pkg::reg_addr_t head_rd_addr,
	output ex_pkg::op_class_t head_oh
);
	localparam int DEPTH = `EX_QUEUE_DEPTH;
	localparam int CW = $clog2(DEPTH + 1);

	logic [DEPTH-1:0]  valid;  // bit 0 is the head
	logic [DEPTH-1:0]  valid_nxt;
	ex_pkg::word_t     ins_q[0:DEPTH-1];
	ex_pkg::word_t     op1_q[0:DEPTH-1];
	ex_pkg::word_t     op2_q[0:DEPTH-1];
	ex_pkg::word_t     pc_q[0:DEPTH-1];
	ex_pkg::reg_addr_t rd_q[0:DEPTH-1];
	ex_pkg::reg_addr_t rs1_q[0:DEPTH-1];
	ex_pkg::reg_addr_t rs2_q[0:DEPTH-1];
	ex_pkg::op_class_t oh_q[0:DEPTH-1];
	ex_pkg::word_t     ins_n[0:DEPTH-1];
	ex_pkg::word_t     op1_n[0:DEPTH-1];
	ex_pkg::word_t     op2_n[0:DEPTH-1];
	ex_pkg::word_t     pc_n[0:DEPTH-1];
	ex_pkg::reg_addr_t rd_n[0:DEPTH-1];
	ex_pkg::reg_addr_t rs1_n[0:DEPTH-1];
	ex_pkg::reg_addr_t rs2_n[0:DEPTH-1];
	ex_pkg::op_class_t oh_n[0:DEPTH-1];
	logic [CW-1:0]     cnt;
	logic [CW-1:0]     kept;
	logic              dup;
	logic              pop;
	logic              bypass;
	logic              capture;
	logic              fwd_ok;

	always_comb begin
		int src;
		cnt = '0;
		dup = 1'b0;
		for (int k = 0; k < DEPTH; k++) begin
			if (valid[k]) begin
				cnt = cnt + 1'b1;
				dup = dup | (pc_q[k] == pc);
			end
		end
		pop = taken && valid[0];
		bypass = taken && !valid[0];  // decode went straight to an alu
		kept = pop ? cnt - 1'b1 : cnt;
		capture = !flush && (oh != '0) && !dup && !bypass && (kept < DEPTH);
		fwd_ok = wb_en && (wb_addr != '0);
		valid_nxt = pop ? valid >> 1 : valid;
		for (int k = 0; k < DEPTH; k++) begin
			src = (pop && k < DEPTH - 1) ? k + 1 : k;
			ins_n[k] = ins_q[src];
			op1_n[k] = op1_q[src];
			op2_n[k] = op2_q[src];
			pc_n[k] = pc_q[src];
			rd_n[k] = rd_q[src];
			rs1_n[k] = rs1_q[src];
			rs2_n[k] = rs2_q[src];
			oh_n[k] = oh_q[src];
			if (fwd_ok && rs1_n[k] == wb_addr) begin
				op1_n[k] = wb_data;
			end
			if (fwd_ok && rs2_n[k] == wb_addr) begin
				op2_n[k] = wb_data;
			end
			if (capture && k == int'(kept)) begin  // append behind kept entries
				valid_nxt[k] = 1'b1;
				ins_n[k] = ins;
				op1_n[k] = (fwd_ok && rs1_addr == wb_addr) ? wb_data : op1;
				op2_n[k] = (fwd_ok && rs2_addr == wb_addr) ? wb_data : op2;
				pc_n[k] = pc;
				rd_n[k] = rd_addr_in;
				rs1_n[k] = rs1_addr;
				rs2_n[k] = rs2_addr;
				oh_n[k] = oh;
			end
		end
		if (flush) begin
			valid_nxt = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			valid <= '0;
		end else begin
			valid <= valid_nxt;
		end
	end

	always_ff @(posedge clk) begin
		ins_q <= ins_n;
		op1_q <= op1_n;
		op2_q <= op2_n;
		pc_q <= pc_n;
		rd_q <= rd_n;
		rs1_q <= rs1_n;
		rs2_q <= rs2_n;
		oh_q <= oh_n;
	end

	assign head_valid = valid[0];
	assign head_ins = ins_q[0];
	assign head_pc = pc_q[0];
	assign head_op1 = op1_q[0];
	assign head_op2 = op2_q[0];
	assign head_rd_addr = rd_q[0];
	assign head_oh = oh_q[0];

	// no hole behind the head after any sequence of pops and appends
	assert property (@(posedge clk) disable iff (!rst) (valid & (valid + 1'b1)) == '0);

endmodule
